/* all.f */
src/MipsPkg.sv
src/IfIdRegister.sv
src/InstructionClassifier.sv
src/RegisterControl.sv
src/RegisterFile.sv
src/DecodeStage.sv
verif/DecodeStageTb.sv

/* src/DecodeStage.sv */
`timescale 1ns/10ps
`default_nettype none

module DecodeStage #(
	parameter int dataWidth = 32,
	parameter int pcWidth = 32
) (
	input wire clock,
	input wire rstN,
	input wire stall,
	input wire flush,
	input wire fetchValid,
	input wire [dataWidth-1:0] instructionIn,
	input wire [pcWidth-1:0] pcIn,
	input wire wbEnable,
	input wire [MipsPkg::regAddrWidth-1:0] wbAddr,
	input wire [dataWidth-1:0] wbData,
	output logic valid,
	output logic [pcWidth-1:0] pc,
	output logic [dataWidth-1:0] port1Data,
	output logic [dataWidth-1:0] port2Data,
	output logic [MipsPkg::regAddrWidth-1:0] writeAddr,
	output MipsPkg::writeDataSourceT writeDataSource,
	output logic writeEnable
);

	logic [dataWidth-1:0] instruction;
	MipsPkg::opcodeT opcode;
	MipsPkg::functT funct;
	logic [MipsPkg::regAddrWidth-1:0] rs, rt, rd;
	logic [MipsPkg::regAddrWidth-1:0] port1Addr, port2Addr;
	MipsPkg::categoryT category;
	MipsPkg::port1AddrSourceT port1AddrSource;
	MipsPkg::port2AddrSourceT port2AddrSource;
	MipsPkg::writeAddrSourceT writeAddrSource;

	IfIdRegister #(.dataWidth(dataWidth), .pcWidth(pcWidth)) ifId (
		.clock(clock), .rstN(rstN), .stall(stall), .flush(flush),
		.fetchValid(fetchValid), .instructionIn(instructionIn), .pcIn(pcIn),
		.instruction(instruction), .pc(pc), .valid(valid)
	);

	////////////////////////////////////////
	// Instruction fields
	////////////////////////////////////////

	assign opcode = MipsPkg::opcodeT'(instruction[31:26]);
	assign rs = instruction[25:21];
	assign rt = instruction[20:16];
	assign rd = instruction[15:11];
	assign funct = MipsPkg::functT'(instruction[5:0]);

	InstructionClassifier classifier (
		.opcode(opcode), .funct(funct), .rt(rt), .category(category)
	);

	RegisterControl control (
		.category(category), .valid(valid),
		.port1AddrSource(port1AddrSource), .port2AddrSource(port2AddrSource),
		.writeAddrSource(writeAddrSource), .writeDataSource(writeDataSource),
		.writeEnable(writeEnable)
	);

	////////////////////////////////////////
	// Register address muxes
	////////////////////////////////////////

	assign port1Addr = (port1AddrSource == MipsPkg::Port1Rt) ? rt : rs;
	assign port2Addr = (port2AddrSource == MipsPkg::Port2Rs) ? rs : rt;

	always_comb begin
		case (writeAddrSource)
			MipsPkg::WriteRd:  writeAddr = rd;
			MipsPkg::WriteR31: writeAddr = 5'd31; // Link register
			default:           writeAddr = rt;
		endcase
	end

	RegisterFile #(.dataWidth(dataWidth)) regFile (
		.clock(clock), .rstN(rstN),
		.port1Addr(port1Addr), .port2Addr(port2Addr),
		.port1Data(port1Data), .port2Data(port2Data),
		.wbEnable(wbEnable), .wbAddr(wbAddr), .wbData(wbData)
	);

endmodule

`default_nettype wire

/* src/IfIdRegister.sv */
`timescale 1ns/10ps
`default_nettype none

module IfIdRegister #(
	parameter int dataWidth = 32,
	parameter int pcWidth = 32
) (
	input wire clock,
	input wire rstN,
	input wire stall,
	input wire flush,
	input wire fetchValid,
	input wire [dataWidth-1:0] instructionIn,
	input wire [pcWidth-1:0] pcIn,
	output logic [dataWidth-1:0] instruction,
	output logic [pcWidth-1:0] pc,
	output logic valid
);

	// Flush beats stall
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN)
			valid <= 1'b0;
		else if (flush)
			valid <= 1'b0;
		else if (!stall)
			valid <= fetchValid;
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			instruction <= instructionIn;
			pc <= pcIn;
		end
	end

	// A flushed slot never shows up as valid downstream
	flushKillsValid: assert property (
		@(posedge clock) disable iff (!rstN)
		flush |=> !valid
	) else $error("IfIdRegister valid set after flush");

endmodule

`default_nettype wire

/* src/InstructionClassifier.sv */
`timescale 1ns/10ps
`default_nettype none

module InstructionClassifier (
	input wire MipsPkg::opcodeT opcode,
	input wire MipsPkg::functT funct,
	input wire [MipsPkg::regAddrWidth-1:0] rt,
	output MipsPkg::categoryT category
);

	always_comb begin
		category = '0;
		case (opcode)
			MipsPkg::OpSpecial:
				case (funct)
					MipsPkg::FunctAddu,
					MipsPkg::FunctSubu,
					MipsPkg::FunctAnd,
					MipsPkg::FunctOr,
					MipsPkg::FunctSlt:
						category.register = 1'b1;
					MipsPkg::FunctSll,
					MipsPkg::FunctSrl,
					MipsPkg::FunctSllv,
					MipsPkg::FunctSrlv:
						category.shift = 1'b1;
					MipsPkg::FunctJr:
						category.jump = 1'b1;
					MipsPkg::FunctJalr: begin
						category.jump = 1'b1;
						category.link = 1'b1;
					end
					default:
						category.reserved = 1'b1; // Unsupported funct
				endcase

			// Bltz, Bgez, then the linking Bltzal, Bgezal
			MipsPkg::OpRegImm:
				case (rt)
					5'd0, 5'd1:
						category.branch = 1'b1;
					5'd16, 5'd17: begin
						category.branch = 1'b1;
						category.link = 1'b1;
					end
					default:
						category.reserved = 1'b1;
				endcase

			MipsPkg::OpJ:
				category.jump = 1'b1;
			MipsPkg::OpJal: begin
				category.jump = 1'b1;
				category.link = 1'b1;
			end
			MipsPkg::OpBeq,
			MipsPkg::OpBne:
				category.branch = 1'b1;
			MipsPkg::OpAddiu,
			MipsPkg::OpSlti,
			MipsPkg::OpAndi,
			MipsPkg::OpOri,
			MipsPkg::OpLui:
				category.immediate = 1'b1;
			MipsPkg::OpLw:
				category.load = 1'b1;
			MipsPkg::OpSw:
				category.store = 1'b1;
			default:
				category.reserved = 1'b1; // Unassigned opcode
		endcase
	end

endmodule

`default_nettype wire

/* src/MipsPkg.sv */
`default_nettype none

package MipsPkg;

	////////////////////////////////////////
	// Register addressing
	////////////////////////////////////////

	localparam int regAddrWidth = 5;

	////////////////////////////////////////
	// Instruction encodings
	////////////////////////////////////////

	// Bits 31:26 of every instruction word
	typedef enum logic [5:0] {
		OpSpecial = 6'h00, // R-type with the operation in funct
		OpRegImm  = 6'h01, // Conditional branches picked by rt
		OpJ       = 6'h02,
		OpJal     = 6'h03,
		OpBeq     = 6'h04,
		OpBne     = 6'h05,
		OpAddiu   = 6'h09,
		OpSlti    = 6'h0a,
		OpAndi    = 6'h0c,
		OpOri     = 6'h0d,
		OpLui     = 6'h0f,
		OpLw      = 6'h23,
		OpSw      = 6'h2b
	} opcodeT;

	// Bits 5:0 of a Special instruction
	typedef enum logic [5:0] {
		FunctSll  = 6'h00,
		FunctSrl  = 6'h02,
		FunctSllv = 6'h04,
		FunctSrlv = 6'h06,
		FunctJr   = 6'h08,
		FunctJalr = 6'h09,
		FunctAddu = 6'h21,
		FunctSubu = 6'h23,
		FunctAnd  = 6'h24,
		FunctOr   = 6'h25,
		FunctSlt  = 6'h2a
	} functT;

	// A linking jump sets both jump and link
	typedef struct packed {
		logic register;
		logic shift;
		logic immediate;
		logic load;
		logic store;
		logic branch;
		logic jump;
		logic link;
		logic reserved;
	} categoryT;

	////////////////////////////////////////
	// Register control selects
	////////////////////////////////////////

	typedef enum logic {
		Port1Rs = 1'b0,
		Port1Rt = 1'b1 // Shifts read rt on port 1
	} port1AddrSourceT;

	typedef enum logic {
		Port2Rt = 1'b0,
		Port2Rs = 1'b1 // Shift amount register
	} port2AddrSourceT;

	typedef enum logic [1:0] {
		WriteRt  = 2'd0,
		WriteRd  = 2'd1,
		WriteR31 = 2'd2 // Link register
	} writeAddrSourceT;

	typedef enum logic [1:0] {
		DataAlu    = 2'd0,
		DataMemory = 2'd1,
		DataPc     = 2'd2 // Return address for links
	} writeDataSourceT;

endpackage

`default_nettype wire

/* src/RegisterControl.sv */
`timescale 1ns/10ps
`default_nettype none

module RegisterControl (
	input wire MipsPkg::categoryT category,
	input wire valid,
	output MipsPkg::port1AddrSourceT port1AddrSource,
	output MipsPkg::port2AddrSourceT port2AddrSource,
	output MipsPkg::writeAddrSourceT writeAddrSource,
	output MipsPkg::writeDataSourceT writeDataSource,
	output logic writeEnable
);

	always_comb begin
		if (category.shift)
			port1AddrSource = MipsPkg::Port1Rt;
		else
			port1AddrSource = MipsPkg::Port1Rs;
	end

	always_comb begin
		if (category.shift)
			port2AddrSource = MipsPkg::Port2Rs;
		else
			port2AddrSource = MipsPkg::Port2Rt;
	end

	// Priority order matters for Jalr, which is jump plus link
	always_comb begin
		if (category.load)
			writeAddrSource = MipsPkg::WriteRt;
		else if (category.link)
			writeAddrSource = MipsPkg::WriteR31;
		else if (category.shift || category.register)
			writeAddrSource = MipsPkg::WriteRd;
		else
			writeAddrSource = MipsPkg::WriteRt; // Immediates
	end

	always_comb begin
		if (category.load)
			writeDataSource = MipsPkg::DataMemory;
		else if (category.link)
			writeDataSource = MipsPkg::DataPc;
		else
			writeDataSource = MipsPkg::DataAlu;
	end

	always_comb begin
		if (!valid)
			writeEnable = 1'b0; // Bubble
		else if (category.link)
			writeEnable = 1'b1;
		else if (category.jump || category.branch || category.store || category.reserved)
			writeEnable = 1'b0;
		else
			writeEnable = 1'b1;
	end

	// The classifier never marks one instruction as both
	loadNotLink: assert #0 (!(valid && category.load && category.link))
		else $error("RegisterControl load and link both set");

endmodule

`default_nettype wire

/* src/RegisterFile.sv */
`timescale 1ns/10ps
`default_nettype none

module RegisterFile #(
	parameter int dataWidth = 32
) (
	input wire clock,
	input wire rstN,
	input wire [MipsPkg::regAddrWidth-1:0] port1Addr,
	input wire [MipsPkg::regAddrWidth-1:0] port2Addr,
	output logic [dataWidth-1:0] port1Data,
	output logic [dataWidth-1:0] port2Data,
	input wire wbEnable,
	input wire [MipsPkg::regAddrWidth-1:0] wbAddr,
	input wire [dataWidth-1:0] wbData
);

	// Register 0 has no storage
	logic [dataWidth-1:0] regs [1:31];

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wbEnable && wbAddr != '0) begin
			regs[wbAddr] <= wbData;
		end
	end

	// Same-cycle write is forwarded to the read
	function automatic logic [dataWidth-1:0] readPort(
		input logic [MipsPkg::regAddrWidth-1:0] addr
	);
		logic [dataWidth-1:0] data;
		if (addr == '0)
			data = '0;
		else if (wbEnable && wbAddr == addr)
			data = wbData;
		else
			data = regs[addr];
		return data;
	endfunction

	always_comb begin
		port1Data = readPort(port1Addr);
		port2Data = readPort(port2Addr);
	end

	zeroReadsZero: assert property (
		@(posedge clock) disable iff (!rstN)
		port1Addr == '0 |-> port1Data == '0
	) else $error("RegisterFile register 0 read nonzero");

endmodule

`default_nettype wire

/* verif/DecodeStageTb.sv */
`timescale 1ns/10ps
`default_nettype none

module DecodeStageTb;

	localparam int dataWidth = 32;
	localparam int pcWidth = 32;
	localparam int timeoutCycles = 16;

	logic clock;
	logic rstN;
	logic stall;
	logic flush;
	logic fetchValid;
	logic [dataWidth-1:0] instructionIn;
	logic [pcWidth-1:0] pcIn;
	logic wbEnable;
	logic [4:0] wbAddr;
	logic [dataWidth-1:0] wbData;
	logic valid;
	logic [pcWidth-1:0] pc;
	logic [dataWidth-1:0] port1Data;
	logic [dataWidth-1:0] port2Data;
	logic [4:0] writeAddr;
	MipsPkg::writeDataSourceT writeDataSource;
	logic writeEnable;

	logic checkEn; // Compare decode outputs once pc reaches expPc
	logic ctrlCheck;
	logic dataCheck;
	logic holdCheck;
	logic idleCheck;
	logic [pcWidth-1:0] expPc;
	logic expValid;
	logic expWe;
	logic [4:0] expAddr;
	MipsPkg::writeDataSourceT expSrc;
	logic [dataWidth-1:0] exp1;
	logic [dataWidth-1:0] exp2;

	logic [dataWidth-1:0] model [0:31]; // Register file contents as written back
	logic [31:0] seed;
	logic [pcWidth-1:0] nextPc;
	int errors;
	int testErrors;
	int testsPassed;
	int testsFailed;

	DecodeStage #(.dataWidth(dataWidth), .pcWidth(pcWidth)) uut (
		.clock(clock), .rstN(rstN), .stall(stall), .flush(flush),
		.fetchValid(fetchValid), .instructionIn(instructionIn), .pcIn(pcIn),
		.wbEnable(wbEnable), .wbAddr(wbAddr), .wbData(wbData),
		.valid(valid), .pc(pc), .port1Data(port1Data), .port2Data(port2Data),
		.writeAddr(writeAddr), .writeDataSource(writeDataSource), .writeEnable(writeEnable)
	);

	always #2 clock = ~clock;

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	validOk: assert property (@(posedge clock) disable iff (!rstN)
		checkEn && pc == expPc |-> valid == expValid)
		else showMismatch("valid", $sampled(expValid), $sampled(valid));
	writeEnableOk: assert property (@(posedge clock) disable iff (!rstN)
		checkEn && pc == expPc |-> writeEnable == expWe)
		else showMismatch("writeEnable", $sampled(expWe), $sampled(writeEnable));
	writeAddrOk: assert property (@(posedge clock) disable iff (!rstN)
		checkEn && ctrlCheck && pc == expPc |-> writeAddr == expAddr)
		else showMismatch("writeAddr", $sampled(expAddr), $sampled(writeAddr));
	writeDataSourceOk: assert property (@(posedge clock) disable iff (!rstN)
		checkEn && ctrlCheck && pc == expPc |-> writeDataSource == expSrc)
		else showMismatch("writeDataSource", $sampled(expSrc), $sampled(writeDataSource));
	port1DataOk: assert property (@(posedge clock) disable iff (!rstN)
		checkEn && dataCheck && pc == expPc |-> port1Data == exp1)
		else showMismatch("port1Data", $sampled(exp1), $sampled(port1Data));
	port2DataOk: assert property (@(posedge clock) disable iff (!rstN)
		checkEn && dataCheck && pc == expPc |-> port2Data == exp2)
		else showMismatch("port2Data", $sampled(exp2), $sampled(port2Data));
	heldPcOk: assert property (@(posedge clock) disable iff (!rstN)
		holdCheck |-> pc == expPc)
		else showMismatch("pc", $sampled(expPc), $sampled(pc));
	idleValidOk: assert property (@(posedge clock) disable iff (!rstN)
		idleCheck |-> !valid)
		else showMismatch("valid", 32'd0, $sampled(valid));
	idleWriteEnableOk: assert property (@(posedge clock) disable iff (!rstN)
		idleCheck |-> !writeEnable)
		else showMismatch("writeEnable", 32'd0, $sampled(writeEnable));

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic showMismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		errors++;
		$display("Fail %s expected %h actual %h", name, expected, actual);
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] nextRand();
		seed = xorshift(seed);
		return seed;
	endfunction

	function automatic logic [4:0] randReg(); // Never register 0
		return 5'(nextRand() % 31 + 1);
	endfunction

	function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] funct);
		return {6'h00, rs, rt, rd, 5'd0, funct};
	endfunction

	task automatic setExpected(input logic v, input logic we, input logic [4:0] addr,
		input MipsPkg::writeDataSourceT src, input logic ctrl, input logic data,
		input logic [31:0] d1, input logic [31:0] d2);
		expValid <= v;
		expWe <= we;
		expAddr <= addr;
		expSrc <= src;
		ctrlCheck <= ctrl;
		dataCheck <= data;
		exp1 <= d1;
		exp2 <= d2;
	endtask

	// Presents one instruction and waits until its pc shows at the decode outputs
	task automatic issue(input logic [31:0] instr, input logic doFlush, input logic doBypass,
		input logic [4:0] bypassAddr, input logic [31:0] bypassData);
		logic [pcWidth-1:0] thisPc;
		int cycles;
		thisPc = nextPc;
		nextPc = nextPc + 4;
		cycles = 0;
		@(posedge clock);
		instructionIn <= instr;
		pcIn <= thisPc;
		fetchValid <= 1'b1;
		flush <= doFlush;
		expPc <= thisPc;
		checkEn <= 1'b1;
		do begin
			@(posedge clock);
			cycles++;
			if (cycles == 1) begin
				flush <= 1'b0;
				wbEnable <= doBypass; // Write lands in the cycle the outputs are checked
				wbAddr <= bypassAddr;
				wbData <= bypassData;
			end
		end while (pc !== thisPc && cycles <= timeoutCycles);
		if (pc !== thisPc) begin
			$display("Timeout, pc %h never reached the decode outputs", thisPc);
			$display("Test FAILED");
			$finish;
		end else begin
			checkEn <= 1'b0;
			wbEnable <= 1'b0;
			if (doBypass && bypassAddr != 5'd0)
				model[bypassAddr] = bypassData;
		end
	endtask

	task automatic checkDecode(input logic [31:0] instr, input logic we, input logic [4:0] addr,
		input MipsPkg::writeDataSourceT src, input logic ctrl, input logic swap);
		logic [31:0] rsValue;
		logic [31:0] rtValue;
		rsValue = model[instr[25:21]];
		rtValue = model[instr[20:16]];
		if (swap)
			setExpected(1'b1, we, addr, src, ctrl, 1'b1, rtValue, rsValue); // Shift
		else
			setExpected(1'b1, we, addr, src, ctrl, 1'b1, rsValue, rtValue);
		issue(instr, 1'b0, 1'b0, 5'd0, '0);
	endtask

	task automatic writeBack(input logic [4:0] addr, input logic [31:0] data);
		@(posedge clock);
		wbEnable <= 1'b1;
		wbAddr <= addr;
		wbData <= data;
		@(posedge clock);
		wbEnable <= 1'b0;
		if (addr != 5'd0)
			model[addr] = data;
	endtask

	task automatic finishTest(input string name);
		@(negedge clock);
		if (errors == testErrors) begin
			testsPassed++;
			$display("%s: passed", name);
		end else begin
			testsFailed++;
			$display("%s: %0d errors", name, errors - testErrors);
		end
		testErrors = errors;
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic registerFileTest();
		logic [4:0] a;
		logic [4:0] b;
		logic [31:0] d;
		for (int r = 1; r < 32; r++)
			writeBack(5'(r), nextRand());
		for (int n = 0; n < 8; n++) begin
			a = randReg();
			b = randReg();
			checkDecode(rType(a, b, 5'd3, 6'h25), 1'b1, 5'd3, MipsPkg::DataAlu, 1'b1, 1'b0);
		end
		writeBack(5'd0, nextRand());
		checkDecode(rType(5'd0, randReg(), 5'd4, 6'h21), 1'b1, 5'd4, MipsPkg::DataAlu, 1'b1, 1'b0);
		a = randReg();
		b = randReg();
		d = nextRand();
		setExpected(1'b1, 1'b1, 5'd5, MipsPkg::DataAlu, 1'b1, 1'b1, d, (b == a) ? d : model[b]);
		issue(rType(a, b, 5'd5, 6'h21), 1'b0, 1'b1, a, d);
		finishTest("register file");
	endtask

	task automatic arithmeticTest();
		logic [4:0] a;
		logic [4:0] b;
		logic [4:0] c;
		logic [31:0] k;
		for (int n = 0; n < 12; n++) begin
			a = randReg();
			b = randReg();
			c = randReg();
			k = nextRand() % 3;
			if (n < 8)
				checkDecode(rType(a, b, c, (k == 0) ? 6'h21 : (k == 1) ? 6'h23 : 6'h2a),
					1'b1, c, MipsPkg::DataAlu, 1'b1, 1'b0);
			else // Sllv then Srl
				checkDecode(rType(a, b, c, n[0] ? 6'h02 : 6'h04),
					1'b1, c, MipsPkg::DataAlu, 1'b1, 1'b1);
		end
		finishTest("register and shift");
	endtask

	task automatic formatTest();
		logic [4:0] a;
		logic [4:0] b;
		logic [31:0] r;
		a = randReg();
		b = randReg();
		r = nextRand();
		checkDecode({6'h23, a, b, r[15:0]}, 1'b1, b, MipsPkg::DataMemory, 1'b1, 1'b0); // Lw
		checkDecode({6'h09, b, a, r[31:16]}, 1'b1, a, MipsPkg::DataAlu, 1'b1, 1'b0);
		checkDecode({6'h0d, a, b, r[15:0]}, 1'b1, b, MipsPkg::DataAlu, 1'b1, 1'b0);
		checkDecode({6'h2b, a, b, r[15:0]}, 1'b0, 5'd0, MipsPkg::DataAlu, 1'b0, 1'b0);
		checkDecode({6'h04, a, b, r[15:0]}, 1'b0, 5'd0, MipsPkg::DataAlu, 1'b0, 1'b0);
		checkDecode({6'h02, r[25:0]}, 1'b0, 5'd0, MipsPkg::DataAlu, 1'b0, 1'b0);
		checkDecode(rType(a, 5'd0, 5'd0, 6'h08), 1'b0, 5'd0, MipsPkg::DataAlu, 1'b0, 1'b0);
		checkDecode({6'h3f, r[25:0]}, 1'b0, 5'd0, MipsPkg::DataAlu, 1'b0, 1'b0); // Unassigned
		// Links always write the return address to register 31
		checkDecode({6'h03, r[25:0]}, 1'b1, 5'd31, MipsPkg::DataPc, 1'b1, 1'b0);
		checkDecode(rType(a, 5'd0, b, 6'h09), 1'b1, 5'd31, MipsPkg::DataPc, 1'b1, 1'b0);
		checkDecode({6'h01, a, 5'd16, r[15:0]}, 1'b1, 5'd31, MipsPkg::DataPc, 1'b1, 1'b0);
		checkDecode({6'h01, b, 5'd17, r[15:0]}, 1'b1, 5'd31, MipsPkg::DataPc, 1'b1, 1'b0);
		finishTest("load store immediate link");
	endtask

	task automatic pipelineTest();
		logic [4:0] a;
		logic [4:0] b;
		logic [4:0] c;
		a = randReg();
		b = randReg();
		c = randReg();
		checkDecode(rType(a, b, c, 6'h23), 1'b1, c, MipsPkg::DataAlu, 1'b1, 1'b0);
		@(posedge clock);
		stall <= 1'b1;
		instructionIn <= rType(b, a, 5'd7, 6'h21); // Must not get in while stalled
		pcIn <= nextPc;
		nextPc = nextPc + 4;
		checkEn <= 1'b1;
		holdCheck <= 1'b1;
		repeat (3) @(posedge clock);
		stall <= 1'b0;
		checkEn <= 1'b0;
		holdCheck <= 1'b0;
		setExpected(1'b0, 1'b0, 5'd0, MipsPkg::DataAlu, 1'b0, 1'b0, '0, '0);
		issue(rType(a, b, c, 6'h21), 1'b1, 1'b0, 5'd0, '0);
		finishTest("pipeline control");
	endtask

	initial begin
		clock = 1'b0;
		rstN = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		fetchValid = 1'b0;
		instructionIn = '0;
		pcIn = '0;
		wbEnable = 1'b0;
		wbAddr = '0;
		wbData = '0;
		checkEn = 1'b0;
		ctrlCheck = 1'b0;
		dataCheck = 1'b0;
		holdCheck = 1'b0;
		idleCheck = 1'b0;
		for (int i = 0; i < 32; i++)
			model[i] = '0;
		seed = 32'd29020;
		nextPc = 32'h0040_0000;
		errors = 0;
		testErrors = 0;
		testsPassed = 0;
		testsFailed = 0;
		repeat (5) @(posedge clock);
		rstN <= 1'b1;
		idleCheck <= 1'b1; // Nothing captured yet
		repeat (3) @(posedge clock);
		idleCheck <= 1'b0;
		finishTest("reset");
		registerFileTest();
		arithmeticTest();
		formatTest();
		pipelineTest();
		$display("Tests passed %0d, failed %0d", testsPassed, testsFailed);
		if (testsFailed == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire
